// ==== logic/sys_arr_pkg.sv ====
package sys_arr_pkg;

    // Array dimension, any power of two from 2 upward
    localparam int N = 4;

    // Element width, all arithmetic wraps modulo 2^DW
    localparam int DW = 16;

    // Row and column index width
    localparam int ROW_W = $clog2(N);

    // Sequencing counter must reach 4N without overflow
    localparam int CNT_W = $clog2(4 * N + 1);

    // Control unit phases
    typedef enum logic [1:0] {
        LOAD,
        COMPUTE,
        UNLOAD
    } cu_state_e;

endpackage

// ==== logic/sys_arr_ifs.sv ====
`timescale 1ns/10ps

// Between the array top and the control unit
interface sysarr_cu_if;
    // Raw load strobes and indices from the client side
    logic                           weight_en;
    logic                           input_en;
    logic                           partial_en;
    logic [sys_arr_pkg::ROW_W-1:0]  row_in_en;
    logic [sys_arr_pkg::ROW_W-1:0]  row_ps_en;

    // Sequencing back to the array
    logic                           fifo_has_space;
    logic [sys_arr_pkg::N-1:0]      in_fifo_shift;
    logic [sys_arr_pkg::N-1:0]      ps_fifo_shift;
    logic                           mac_shift;
    logic [sys_arr_pkg::N-1:0]      out_fifo_shift;
    logic                           out_valid;
    logic [sys_arr_pkg::ROW_W-1:0]  out_row;

    modport array (
        output weight_en, input_en, partial_en, row_in_en, row_ps_en,
        input  fifo_has_space, in_fifo_shift, ps_fifo_shift, mac_shift,
        input  out_fifo_shift, out_valid, out_row
    );

    modport control_unit (
        input  weight_en, input_en, partial_en, row_in_en, row_ps_en,
        output fifo_has_space, in_fifo_shift, ps_fifo_shift, mac_shift,
        output out_fifo_shift, out_valid, out_row
    );
endinterface

// One grid cell of the array
interface sysarr_mac_if;
    logic                        weight_load;
    logic [sys_arr_pkg::DW-1:0]  weight;
    logic [sys_arr_pkg::DW-1:0]  in_value;
    logic [sys_arr_pkg::DW-1:0]  in_accumulate;
    logic                        mac_shift;

    // Rightward data and downward sum
    logic [sys_arr_pkg::DW-1:0]  in_pass;
    logic [sys_arr_pkg::DW-1:0]  out_accumulate;

    modport mac (
        input  weight_load, weight, in_value, in_accumulate, mac_shift,
        output in_pass, out_accumulate
    );

    modport array (
        output weight_load, weight, in_value, in_accumulate, mac_shift,
        input  in_pass, out_accumulate
    );
endinterface

// Parallel-load shift FIFO for input and partial-sum columns
interface sysarr_fifo_if;
    logic                                        load;
    logic                                        shift;
    logic [sys_arr_pkg::N*sys_arr_pkg::DW-1:0]   load_values;
    logic [sys_arr_pkg::DW-1:0]                  out;

    modport fifo (
        input  load, shift, load_values,
        output out
    );

    modport array (
        output load, shift, load_values,
        input  out
    );
endinterface

// ==== logic/sysarr_mac.sv ====
`timescale 1ns/10ps

module sysarr_mac (
    input logic clk,
    input logic nRST,
    sysarr_mac_if.mac mac_if
);
    import sys_arr_pkg::*;

    logic [DW-1:0] weight_q;
    logic [DW-1:0] product;

    // Stationary weight, held across the whole matrix
    always_ff @(posedge clk) begin
        if (mac_if.weight_load) begin
            weight_q <= mac_if.weight;
        end
    end

    // Low DW bits only, so signedness does not matter
    assign product = mac_if.in_value * weight_q;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            mac_if.in_pass        <= '0;
            mac_if.out_accumulate <= '0;
        end else if (mac_if.mac_shift) begin
            mac_if.in_pass        <= mac_if.in_value;
            mac_if.out_accumulate <= mac_if.in_accumulate + product;
        end
    end

endmodule

// ==== logic/sysarr_fifo.sv ====
`timescale 1ns/10ps

module sysarr_fifo (
    input logic clk,
    input logic nRST,
    sysarr_fifo_if.fifo fifo
);
    import sys_arr_pkg::*;

    logic [DW-1:0] entries [N];

    // Entry 0 is the head
    assign fifo.out = entries[0];

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            for (int k = 0; k < N; k++) begin
                entries[k] <= '0;
            end
        end else if (fifo.load) begin
            for (int k = 0; k < N; k++) begin
                entries[k] <= fifo.load_values[k*DW +: DW];
            end
        end else if (fifo.shift) begin
            for (int k = 0; k < N - 1; k++) begin
                entries[k] <= entries[k+1];
            end
            // Zeros behind the data keep later products harmless
            entries[N-1] <= '0;
        end
    end

endmodule

// ==== logic/sysarr_out_fifo.sv ====
`timescale 1ns/10ps

module sysarr_out_fifo (
    input  logic                                      clk,
    input  logic                                      nRST,
    input  logic                                      shift,
    input  logic [sys_arr_pkg::DW-1:0]                shift_value,
    output logic [sys_arr_pkg::N*sys_arr_pkg::DW-1:0] column
);
    import sys_arr_pkg::*;

    // New values enter at the top element and move toward element 0,
    // so after N shifts element r holds row r of this column
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            column <= '0;
        end else if (shift) begin
            column <= {shift_value, column[N*DW-1:DW]};
        end
    end

endmodule

// ==== logic/sysarr_control_unit.sv ====
`timescale 1ns/10ps

module sysarr_control_unit (
    input logic clk,
    input logic nRST,
    sysarr_cu_if.control_unit cu
);
    import sys_arr_pkg::*;

    cu_state_e        state;
    logic [N-1:0]     w_mask;
    logic [N-1:0]     i_mask;
    logic [N-1:0]     p_mask;
    logic [N-1:0]     w_mask_nxt;
    logic [N-1:0]     i_mask_nxt;
    logic [N-1:0]     p_mask_nxt;
    logic             loading;
    logic             computing;
    logic             masks_full;
    logic [CNT_W-1:0] cnt;
    logic [ROW_W-1:0] row_q;

    function automatic logic [N-1:0] row_bit(input logic [ROW_W-1:0] row);
        logic [N-1:0] bits;
        bits = '0;
        bits[row] = 1'b1;
        return bits;
    endfunction

    assign loading   = (state == LOAD);
    assign computing = (state == COMPUTE);

    // Strobes only count while the array is waiting for data
    always_comb begin
        w_mask_nxt = w_mask;
        i_mask_nxt = i_mask;
        p_mask_nxt = p_mask;
        if (loading && cu.weight_en) begin
            w_mask_nxt = w_mask | row_bit(cu.row_in_en);
        end
        if (loading && cu.input_en) begin
            i_mask_nxt = i_mask | row_bit(cu.row_in_en);
        end
        if (loading && cu.partial_en) begin
            p_mask_nxt = p_mask | row_bit(cu.row_ps_en);
        end
        masks_full = &{w_mask_nxt, i_mask_nxt, p_mask_nxt};
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state  <= LOAD;
            w_mask <= '0;
            i_mask <= '0;
            p_mask <= '0;
            cnt    <= '0;
            row_q  <= '0;
        end else begin
            case (state)
                LOAD: begin
                    w_mask <= w_mask_nxt;
                    i_mask <= i_mask_nxt;
                    p_mask <= p_mask_nxt;
                    if (masks_full) begin
                        state <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    // Last column's final sum lands at step 3N-2
                    if (cnt == CNT_W'(3 * N - 2)) begin
                        cnt   <= '0;
                        state <= UNLOAD;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                UNLOAD: begin
                    if (row_q == ROW_W'(N - 1)) begin
                        row_q  <= '0;
                        w_mask <= '0;
                        i_mask <= '0;
                        p_mask <= '0;
                        state  <= LOAD;
                    end else begin
                        row_q <= row_q + 1'b1;
                    end
                end
                default: begin
                    state <= LOAD;
                end
            endcase
        end
    end

    // Row m of the grid starts m steps late; column n sums arrive from step N+n
    always_comb begin
        for (int k = 0; k < N; k++) begin
            cu.in_fifo_shift[k]  = computing && (cnt >= CNT_W'(k));
            cu.ps_fifo_shift[k]  = computing && (cnt >= CNT_W'(N + k))
                                   && (cnt < CNT_W'(2 * N + k));
            cu.out_fifo_shift[k] = cu.ps_fifo_shift[k];
        end
    end

    assign cu.mac_shift      = computing;
    assign cu.fifo_has_space = loading;
    assign cu.out_valid      = (state == UNLOAD);
    assign cu.out_row        = row_q;

endmodule

// ==== logic/systolic_array.sv ====
`timescale 1ns/10ps

module systolic_array (
    input  logic                                      clk,
    input  logic                                      nRST,
    input  logic                                      weight_en,
    input  logic                                      input_en,
    input  logic                                      partial_en,
    input  logic [sys_arr_pkg::ROW_W-1:0]             row_in_en,
    input  logic [sys_arr_pkg::ROW_W-1:0]             row_ps_en,
    input  logic [sys_arr_pkg::N*sys_arr_pkg::DW-1:0] array_in,
    input  logic [sys_arr_pkg::N*sys_arr_pkg::DW-1:0] array_in_partials,
    output logic                                      fifo_has_space,
    output logic                                      out_en,
    output logic [sys_arr_pkg::ROW_W-1:0]             row_out,
    output logic [sys_arr_pkg::N*sys_arr_pkg::DW-1:0] array_output,
    output logic                                      drained
);
    import sys_arr_pkg::*;

    // Element k of every N*DW bus sits at bits [k*DW +: DW]
    logic [N-1:0]    load_w;
    logic [N-1:0]    load_i;
    logic [N-1:0]    load_p;
    logic [DW-1:0]   col_sum [N];
    logic [N*DW-1:0] collected [N];

    sysarr_cu_if   cu_bus ();
    sysarr_mac_if  mac_bus [N*N] ();
    sysarr_fifo_if in_bus [N] ();
    sysarr_fifo_if ps_bus [N] ();

    sysarr_control_unit u_cu (
        .clk  (clk),
        .nRST (nRST),
        .cu   (cu_bus.control_unit)
    );

    assign cu_bus.weight_en  = weight_en;
    assign cu_bus.input_en   = input_en;
    assign cu_bus.partial_en = partial_en;
    assign cu_bus.row_in_en  = row_in_en;
    assign cu_bus.row_ps_en  = row_ps_en;

    // Per-row load strobes, dropped while a matrix is in flight
    always_comb begin
        load_w = '0;
        load_i = '0;
        load_p = '0;
        if (cu_bus.fifo_has_space) begin
            if (weight_en) begin
                load_w[row_in_en] = 1'b1;
            end
            if (input_en) begin
                load_i[row_in_en] = 1'b1;
            end
            if (partial_en) begin
                load_p[row_ps_en] = 1'b1;
            end
        end
    end

    // Row m: input column m of A enters from the left, weight row m is stationary
    for (genvar m = 0; m < N; m++) begin : g_row
        sysarr_fifo u_in_fifo (
            .clk  (clk),
            .nRST (nRST),
            .fifo (in_bus[m].fifo)
        );
        assign in_bus[m].load        = load_i[m];
        assign in_bus[m].shift       = cu_bus.in_fifo_shift[m];
        assign in_bus[m].load_values = array_in;

        for (genvar n = 0; n < N; n++) begin : g_cell
            sysarr_mac u_mac (
                .clk    (clk),
                .nRST   (nRST),
                .mac_if (mac_bus[m*N+n].mac)
            );
            assign mac_bus[m*N+n].weight_load = load_w[m];
            assign mac_bus[m*N+n].weight      = array_in[n*DW +: DW];
            assign mac_bus[m*N+n].mac_shift   = cu_bus.mac_shift;

            if (n == 0) begin : g_left_edge
                assign mac_bus[m*N+n].in_value = in_bus[m].out;
            end else begin : g_left_link
                assign mac_bus[m*N+n].in_value = mac_bus[m*N+n-1].in_pass;
            end

            if (m == 0) begin : g_top_edge
                assign mac_bus[m*N+n].in_accumulate = '0;
            end else begin : g_top_link
                assign mac_bus[m*N+n].in_accumulate = mac_bus[(m-1)*N+n].out_accumulate;
            end
        end
    end

    // Column n: partial column n meets the bottom cell, result collected serially
    for (genvar n = 0; n < N; n++) begin : g_col
        sysarr_fifo u_ps_fifo (
            .clk  (clk),
            .nRST (nRST),
            .fifo (ps_bus[n].fifo)
        );
        assign ps_bus[n].load        = load_p[n];
        assign ps_bus[n].shift       = cu_bus.ps_fifo_shift[n];
        assign ps_bus[n].load_values = array_in_partials;

        assign col_sum[n] = mac_bus[(N-1)*N+n].out_accumulate + ps_bus[n].out;

        sysarr_out_fifo u_out_fifo (
            .clk         (clk),
            .nRST        (nRST),
            .shift       (cu_bus.out_fifo_shift[n]),
            .shift_value (col_sum[n]),
            .column      (collected[n])
        );
    end

    // Row r of C gathers element r from every column collector
    always_comb begin
        for (int n = 0; n < N; n++) begin
            array_output[n*DW +: DW] = collected[n][cu_bus.out_row*DW +: DW];
        end
    end

    assign fifo_has_space = cu_bus.fifo_has_space;
    assign out_en         = cu_bus.out_valid;
    assign row_out        = cu_bus.out_row;

    // High when nothing is loaded or in flight
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            drained <= 1'b1;
        end else if (cu_bus.out_valid && (cu_bus.out_row == ROW_W'(N - 1))) begin
            drained <= 1'b1;
        end else if (|{load_w, load_i, load_p}) begin
            drained <= 1'b0;
        end
    end

endmodule

// ==== test/tb_systolic_array.sv ====
`timescale 1ns/10ps

module tb_systolic_array;
    import sys_arr_pkg::*;

    localparam int NCASES     = 5;
    localparam int CLK_PERIOD = 20;

    // Data modes
    localparam int D_IDENT  = 0;
    localparam int D_RANDOM = 1;
    localparam int D_MAX    = 2;

    // Load orders
    localparam int O_ASCEND     = 0;
    localparam int O_REVERSE    = 1;
    localparam int O_INTERLEAVE = 2;

    // Generous bound on load, compute and unload per case
    localparam int WATCHDOG_CYCLES = NCASES * (6 * N + 20) + 20;

    logic            clk;
    logic            nRST;
    logic            weight_en;
    logic            input_en;
    logic            partial_en;
    logic [ROW_W-1:0] row_in_en;
    logic [ROW_W-1:0] row_ps_en;
    logic [N*DW-1:0] array_in;
    logic [N*DW-1:0] array_in_partials;
    logic            fifo_has_space;
    logic            out_en;
    logic [ROW_W-1:0] row_out;
    logic [N*DW-1:0] array_output;
    logic            drained;

    // Case table with expected results
    int            data_mode [NCASES];
    int            order_mode [NCASES];
    bit            junk_mode [NCASES];
    logic [DW-1:0] a_tab [NCASES][N][N];
    logic [DW-1:0] w_tab [NCASES][N][N];
    logic [DW-1:0] p_tab [NCASES][N][N];
    logic [DW-1:0] exp_tab [NCASES][N][N];

    logic [31:0] lcg_state;
    int          errors;
    int          checks;

    systolic_array dut_i (
        .clk               (clk),
        .nRST              (nRST),
        .weight_en         (weight_en),
        .input_en          (input_en),
        .partial_en        (partial_en),
        .row_in_en         (row_in_en),
        .row_ps_en         (row_ps_en),
        .array_in          (array_in),
        .array_in_partials (array_in_partials),
        .fifo_has_space    (fifo_has_space),
        .out_en            (out_en),
        .row_out           (row_out),
        .array_output      (array_output),
        .drained           (drained)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper bits of the LCG are the better ones
    function automatic logic [DW-1:0] rand_word();
        logic [31:0] r;
        r = lcg_next();
        return r[31 -: DW];
    endfunction

    function automatic logic [N*DW-1:0] random_bus();
        logic [N*DW-1:0] v;
        for (int k = 0; k < N; k++) begin
            v[k*DW +: DW] = rand_word();
        end
        return v;
    endfunction

    // Element n of weight row m feeds cell (m, n)
    function automatic logic [N*DW-1:0] weight_row(input int c, input int m);
        logic [N*DW-1:0] v;
        for (int n = 0; n < N; n++) begin
            v[n*DW +: DW] = w_tab[c][m][n];
        end
        return v;
    endfunction

    // Element r of input column m is A[r][m]
    function automatic logic [N*DW-1:0] input_col(input int c, input int m);
        logic [N*DW-1:0] v;
        for (int r = 0; r < N; r++) begin
            v[r*DW +: DW] = a_tab[c][r][m];
        end
        return v;
    endfunction

    function automatic logic [N*DW-1:0] partial_col(input int c, input int n);
        logic [N*DW-1:0] v;
        for (int r = 0; r < N; r++) begin
            v[r*DW +: DW] = p_tab[c][r][n];
        end
        return v;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR @ %0t ns: %s got %0h expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic build_table();
        logic [DW-1:0] acc;
        data_mode  = '{D_IDENT, D_RANDOM, D_RANDOM, D_MAX, D_RANDOM};
        order_mode = '{O_ASCEND, O_REVERSE, O_INTERLEAVE, O_ASCEND, O_INTERLEAVE};
        junk_mode  = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
        for (int c = 0; c < NCASES; c++) begin
            for (int r = 0; r < N; r++) begin
                for (int n = 0; n < N; n++) begin
                    case (data_mode[c])
                        D_IDENT: begin
                            a_tab[c][r][n] = rand_word();
                            w_tab[c][r][n] = (r == n) ? DW'(1) : DW'(0);
                            p_tab[c][r][n] = '0;
                        end
                        D_MAX: begin
                            a_tab[c][r][n] = '1;
                            w_tab[c][r][n] = '1;
                            p_tab[c][r][n] = '1;
                        end
                        default: begin
                            a_tab[c][r][n] = rand_word();
                            w_tab[c][r][n] = rand_word();
                            p_tab[c][r][n] = rand_word();
                        end
                    endcase
                end
            end
            // C = A*W + P with every step wrapping at DW bits
            for (int r = 0; r < N; r++) begin
                for (int n = 0; n < N; n++) begin
                    acc = p_tab[c][r][n];
                    for (int m = 0; m < N; m++) begin
                        acc = acc + a_tab[c][r][m] * w_tab[c][m][n];
                    end
                    exp_tab[c][r][n] = acc;
                end
            end
        end
    endtask

    task automatic drive_idle();
        weight_en  = 1'b0;
        input_en   = 1'b0;
        partial_en = 1'b0;
    endtask

    // Random strobes that the busy array must ignore
    task automatic drive_junk();
        logic [31:0] r;
        r = lcg_next();
        weight_en         = r[20];
        input_en          = !r[20] && r[21];
        partial_en        = r[22];
        row_in_en         = r[24 +: ROW_W];
        row_ps_en         = r[28 +: ROW_W];
        array_in          = random_bus();
        array_in_partials = random_bus();
    endtask

    task automatic drive_load(input bit w, input bit i, input bit p, input int row_i,
                              input int row_p, input logic [N*DW-1:0] data,
                              input logic [N*DW-1:0] data_ps);
        check_value(fifo_has_space, 1, "fifo_has_space before load");
        weight_en         = w;
        input_en          = i;
        partial_en        = p;
        row_in_en         = ROW_W'(row_i);
        row_ps_en         = ROW_W'(row_p);
        array_in          = data;
        array_in_partials = data_ps;
        @(posedge clk);
        #2;
        drive_idle();
        check_value(drained, 0, "drained after accepted load");
    endtask

    task automatic load_case(input int c);
        int wi;
        int ii;
        int pi;
        if (order_mode[c] == O_INTERLEAVE) begin
            // Garbage loads that the real ones below overwrite
            drive_load(1, 0, 1, N - 1, 0, random_bus(), random_bus());
            drive_load(0, 1, 0, 0, 0, random_bus(), '0);
        end
        for (int k = 0; k < N; k++) begin
            case (order_mode[c])
                O_REVERSE: begin
                    wi = N - 1 - k;
                    ii = N - 1 - k;
                    pi = N - 1 - k;
                end
                O_INTERLEAVE: begin
                    wi = (3 * k + 1) % N;
                    ii = N - 1 - k;
                    pi = k;
                end
                default: begin
                    wi = k;
                    ii = k;
                    pi = k;
                end
            endcase
            if (order_mode[c] == O_INTERLEAVE) begin
                drive_load(0, 1, 0, ii, 0, input_col(c, ii), '0);
                drive_load(1, 0, 1, wi, pi, weight_row(c, wi), partial_col(c, pi));
            end else begin
                drive_load(1, 0, 1, wi, pi, weight_row(c, wi), partial_col(c, pi));
                drive_load(0, 1, 0, ii, 0, input_col(c, ii), '0);
            end
        end
    endtask

    task automatic run_case(input int c);
        logic [DW-1:0] got;
        load_case(c);
        check_value(fifo_has_space, 0, $sformatf("case %0d fifo_has_space after loads", c));
        while (out_en !== 1'b1) begin
            if (junk_mode[c]) begin
                drive_junk();
            end
            @(posedge clk);
            #2;
            drive_idle();
        end
        // Rows must come in order on back-to-back cycles
        for (int r = 0; r < N; r++) begin
            check_value(out_en, 1, $sformatf("case %0d out_en for row %0d", c, r));
            check_value(row_out, r, $sformatf("case %0d row_out", c));
            for (int n = 0; n < N; n++) begin
                got = array_output[n*DW +: DW];
                check_value(got, exp_tab[c][r][n],
                            $sformatf("case %0d C[%0d][%0d]", c, r, n));
            end
            @(posedge clk);
            #2;
        end
        check_value(out_en, 0, $sformatf("case %0d out_en after last row", c));
        check_value(fifo_has_space, 1, $sformatf("case %0d fifo_has_space at end", c));
        check_value(drained, 1, $sformatf("case %0d drained at end", c));
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        clk               = 1'b0;
        nRST              = 1'b0;
        weight_en         = 1'b0;
        input_en          = 1'b0;
        partial_en        = 1'b0;
        row_in_en         = '0;
        row_ps_en         = '0;
        array_in          = '0;
        array_in_partials = '0;
        lcg_state         = 32'h9bcc;
        errors            = 0;
        checks            = 0;
        build_table();

        repeat (4) @(posedge clk);
        #2;
        nRST = 1'b1;
        check_value(fifo_has_space, 1, "fifo_has_space after reset");
        check_value(drained, 1, "drained after reset");
        check_value(out_en, 0, "out_en after reset");

        for (int c = 0; c < NCASES; c++) begin
            run_case(c);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
logic/sys_arr_pkg.sv
logic/sys_arr_ifs.sv
logic/sysarr_mac.sv
logic/sysarr_fifo.sv
logic/sysarr_out_fifo.sv
logic/sysarr_control_unit.sv
logic/systolic_array.sv
test/tb_systolic_array.sv

// ==== Bender.yml ====
package:
  name: systolic_array

dependencies: {}

sources:
  - files:
      - logic/sys_arr_pkg.sv
      - logic/sys_arr_ifs.sv
      - logic/sysarr_mac.sv
      - logic/sysarr_fifo.sv
      - logic/sysarr_out_fifo.sv
      - logic/sysarr_control_unit.sv
      - logic/systolic_array.sv
  - target: test
    files:
      - test/tb_systolic_array.sv
